// ==== ram_wrap_defines.svh ====
/*
 * size macros for the 80x72 two-port RAM wrapper
 * depth, address width, data width and MBIST pattern width
 */

`ifndef RAM_WRAP_DEFINES_SVH
`define RAM_WRAP_DEFINES_SVH

// number of storage entries
`define RAM_DEPTH 80

// address width covering RAM_DEPTH entries
`define RAM_ADDR_W 7

// data word width
`define RAM_DATA_W 72

// mbist pattern width, repeated across the data word
`define MBIST_DI_W 2

`endif

// ==== ram_wrap_pkg.sv ====
/*
 * shared types for the RAM wrapper
 * address and data words, mbist pattern, request struct
 */

`include "ram_wrap_defines.svh"

package ram_wrap_pkg;

  // ------------------------------------------------------------
  // basic words
  // ------------------------------------------------------------
  typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [`RAM_DATA_W-1:0] ram_data_t;
  typedef logic [`MBIST_DI_W-1:0] mbist_di_t;

  // ------------------------------------------------------------
  // one request to the array
  // used for functional, mbist and the muxed request
  // ------------------------------------------------------------
  typedef struct packed {
    logic      re;
    logic      we;
    ram_addr_t ra;
    ram_addr_t wa;
    // mbist request carries only the pattern in the low bits
    ram_data_t wd;
  } ram_req_t;

endpackage

// ==== ram_port_mux.sv ====
/*
 * request selection between functional and mbist ports
 * mbist enable and mbist_ce registers
 * capture and bypass qualifiers for the output stage
 */

`timescale 1ns/1ps

`include "ram_wrap_defines.svh"

module ram_port_mux (
  input  logic                  clk,
  input  logic                  mbist_ramaccess_rst_,
  input  ram_wrap_pkg::ram_req_t func_req,
  input  ram_wrap_pkg::ram_req_t mbist_req,
  input  logic                  mbist_en,
  input  logic                  ore,
  input  logic                  byp_sel,
  output ram_wrap_pkg::ram_req_t array_req,
  output logic                  func_active,
  output logic                  cap_en,
  output logic                  byp_active
);

  import ram_wrap_pkg::*;

  logic      mbist_en_r;
  logic      mbist_ce_d;
  mbist_di_t mbist_pat;

  // ------------------------------------------------------------
  // mode and read-enable registers
  // ------------------------------------------------------------

  // mbist mode starts one cycle after mbist_en rises
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_en_r <= 1'b0;
    end else begin
      mbist_en_r <= mbist_en;
    end
  end

  // mbist_ce lines up with the read data for the capture stage
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_ce_d <= 1'b0;
    end else begin
      mbist_ce_d <= mbist_req.re;
    end
  end

  // ------------------------------------------------------------
  // request select
  // ------------------------------------------------------------
  assign mbist_pat = mbist_req.wd[`MBIST_DI_W-1:0];

  always_comb begin
    if (mbist_en_r) begin
      array_req.re = mbist_req.re;
      array_req.we = mbist_req.we;
      array_req.ra = mbist_req.ra;
      array_req.wa = mbist_req.wa;
      // pattern fills the whole word
      array_req.wd = {(`RAM_DATA_W / `MBIST_DI_W){mbist_pat}};
    end else begin
      array_req = func_req;
    end
  end

  // ------------------------------------------------------------
  // qualifiers for the downstream blocks
  // ------------------------------------------------------------
  assign func_active = !mbist_en_r;
  assign cap_en      = mbist_en_r ? mbist_ce_d : ore;
  assign byp_active  = byp_sel & !mbist_en_r;

endmodule

// ==== ram_array.sv ====
/*
 * behavioral 80x72 storage
 * one write port, one registered read port
 */

`timescale 1ns/1ps

`include "ram_wrap_defines.svh"

module ram_array (
  input  logic                   clk,
  input  logic                   mbist_ramaccess_rst_,
  input  ram_wrap_pkg::ram_req_t  array_req,
  output ram_wrap_pkg::ram_data_t rd_data
);

  import ram_wrap_pkg::*;

  // storage holds its contents through reset
  ram_data_t mem [`RAM_DEPTH];

  // ------------------------------------------------------------
  // write port
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (array_req.we) begin
      mem[array_req.wa] <= array_req.wd;
    end
  end

  // ------------------------------------------------------------
  // read port
  // ------------------------------------------------------------

  // old data on a same-address write, forwarding fixes that up later
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      rd_data <= '0;
    end else if (array_req.re) begin
      rd_data <= mem[array_req.ra];
    end
  end

  // addresses 80..127 are not backed by storage
  a_wa_in_range: assert property (
    @(posedge clk) disable iff (!mbist_ramaccess_rst_)
    array_req.we |-> (array_req.wa < `RAM_DEPTH)
  ) else $error("write address %0d out of range", array_req.wa);

  a_ra_in_range: assert property (
    @(posedge clk) disable iff (!mbist_ramaccess_rst_)
    array_req.re |-> (array_req.ra < `RAM_DEPTH)
  ) else $error("read address %0d out of range", array_req.ra);

endmodule

// ==== ram_wthru_ctrl.sv ====
/*
 * write-through detection for same-address read and write
 * forward flag and forwarded data register
 */

`timescale 1ns/1ps

module ram_wthru_ctrl (
  input  logic                   clk,
  input  logic                   mbist_ramaccess_rst_,
  input  ram_wrap_pkg::ram_req_t  func_req,
  input  logic                   func_active,
  output logic                   fwd_en,
  output ram_wrap_pkg::ram_data_t fwd_data
);

  import ram_wrap_pkg::*;

  logic      wthru;
  ram_data_t wthru_di;

  // read and write hit the same entry in one cycle
  assign wthru = func_active & func_req.re & func_req.we &
                 (func_req.ra == func_req.wa);

  // ------------------------------------------------------------
  // forward flag
  // held until a later read without a match, dropped in mbist mode
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      fwd_en <= 1'b0;
    end else begin
      fwd_en <= (wthru | (fwd_en & !func_req.re)) & func_active;
    end
  end

  // new write data replaces the stale array read
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      wthru_di <= '0;
    end else if (wthru) begin
      wthru_di <= func_req.wd;
    end
  end

  assign fwd_data = wthru_di;

endmodule

// ==== ram_dout_capture.sv ====
/*
 * output source mux and capture register
 * drives dout and mbist_do from the same register
 */

`timescale 1ns/1ps

module ram_dout_capture (
  input  logic                   clk,
  input  logic                   mbist_ramaccess_rst_,
  input  ram_wrap_pkg::ram_data_t rd_data,
  input  logic                   fwd_en,
  input  ram_wrap_pkg::ram_data_t fwd_data,
  input  logic                   byp_active,
  input  ram_wrap_pkg::ram_data_t dbyp,
  input  logic                   cap_en,
  output ram_wrap_pkg::ram_data_t dout,
  output ram_wrap_pkg::ram_data_t mbist_do
);

  import ram_wrap_pkg::*;

  ram_data_t cap_src;
  ram_data_t cap_q;

  // ------------------------------------------------------------
  // source select
  // bypass first, then write-through, then the array
  // ------------------------------------------------------------
  always_comb begin
    if (byp_active) begin
      cap_src = dbyp;
    end else if (fwd_en) begin
      cap_src = fwd_data;
    end else begin
      cap_src = rd_data;
    end
  end

  // ------------------------------------------------------------
  // capture register
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      cap_q <= '0;
    end else if (cap_en) begin
      cap_q <= cap_src;
    end
  end

  // mbist compares against the same captured word
  assign dout     = cap_q;
  assign mbist_do = cap_q;

endmodule

// ==== ram_wrap_top.sv ====
/*
 * top level of the 80x72 RAM wrapper
 * packs functional and mbist requests, connects the four blocks
 */

`timescale 1ns/1ps

`include "ram_wrap_defines.svh"

module ram_wrap_top (
  input  logic                    clk,
  input  logic                    mbist_ramaccess_rst_,
  // functional port
  input  logic                    re,
  input  logic                    we,
  input  ram_wrap_pkg::ram_addr_t  ra,
  input  ram_wrap_pkg::ram_addr_t  wa,
  input  ram_wrap_pkg::ram_data_t  di,
  input  logic                    ore,
  input  logic                    byp_sel,
  input  ram_wrap_pkg::ram_data_t  dbyp,
  // mbist port
  input  logic                    mbist_en,
  input  logic                    mbist_we,
  input  logic                    mbist_ce,
  input  ram_wrap_pkg::ram_addr_t  mbist_ra,
  input  ram_wrap_pkg::ram_addr_t  mbist_wa,
  input  ram_wrap_pkg::mbist_di_t  mbist_di,
  output ram_wrap_pkg::ram_data_t  dout,
  output ram_wrap_pkg::ram_data_t  mbist_do
);

  import ram_wrap_pkg::*;

  ram_req_t  func_req;
  ram_req_t  mbist_req;
  ram_req_t  array_req;
  ram_data_t rd_data;
  ram_data_t fwd_data;
  logic      func_active;
  logic      fwd_en;
  logic      cap_en;
  logic      byp_active;

  // ------------------------------------------------------------
  // request packing
  // ------------------------------------------------------------
  assign func_req  = '{re: re, we: we, ra: ra, wa: wa, wd: di};
  assign mbist_req = '{re: mbist_ce, we: mbist_we, ra: mbist_ra, wa: mbist_wa,
                       wd: {{(`RAM_DATA_W - `MBIST_DI_W){1'b0}}, mbist_di}};

  ram_port_mux u_port_mux (
    .clk, .mbist_ramaccess_rst_, .func_req, .mbist_req, .mbist_en,
    .ore, .byp_sel, .array_req, .func_active, .cap_en, .byp_active
  );

  ram_array u_array (
    .clk, .mbist_ramaccess_rst_, .array_req, .rd_data
  );

  ram_wthru_ctrl u_wthru (
    .clk, .mbist_ramaccess_rst_, .func_req, .func_active, .fwd_en, .fwd_data
  );

  ram_dout_capture u_capture (
    .clk, .mbist_ramaccess_rst_, .rd_data, .fwd_en, .fwd_data,
    .byp_active, .dbyp, .cap_en, .dout, .mbist_do
  );

endmodule

// ==== tb_ram_wrap.sv ====
/*
 * self-checking testbench for the 80x72 RAM wrapper
 * step table with expected dout, applied in a loop
 */

`timescale 1ns/1ps

`include "ram_wrap_defines.svh"

module tb_ram_wrap;

  import ram_wrap_pkg::*;

  typedef enum logic [2:0] {
    op_write, op_read, op_wr_rd, op_bypass, op_mb_write, op_mb_read, op_idle
  } op_kind_t;

  // one table row, data holds the mbist pattern for mbist steps
  typedef struct packed {
    op_kind_t  kind;
    ram_addr_t ra;
    ram_addr_t wa;
    ram_data_t data;
    ram_data_t exp;
  } step_t;

  logic      clk;
  logic      mbist_ramaccess_rst_;
  logic      re, we, ore, byp_sel;
  ram_addr_t ra, wa;
  ram_data_t di, dbyp;
  logic      mbist_en, mbist_we, mbist_ce;
  ram_addr_t mbist_ra, mbist_wa;
  mbist_di_t mbist_di;
  ram_data_t dout, mbist_do;

  step_t     steps [$];
  ram_data_t model_mem [`RAM_DEPTH];
  ram_data_t last_dout;
  integer    seed;
  integer    errors;
  integer    checks;
  integer    timeouts;
  logic      in_mbist;

  ram_wrap_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held for 16 cycles
  initial begin
    repeat (16) @(negedge clk);
    mbist_ramaccess_rst_ = 1'b1;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic ram_data_t rand_word();
    ram_data_t w;
    w[31:0]  = $random(seed);
    w[63:32] = $random(seed);
    w[71:64] = $random(seed);
    return w;
  endfunction

  task automatic drive_idle();
    re       = 1'b0;
    we       = 1'b0;
    ore      = 1'b0;
    byp_sel  = 1'b0;
    mbist_we = 1'b0;
    mbist_ce = 1'b0;
  endtask

  // functional traffic that mbist mode must ignore
  task automatic drive_func_noise();
    re  = 1'b1;
    we  = 1'b1;
    ra  = 7'd5;
    wa  = 7'd5;
    di  = rand_word();
    ore = 1'b1;
  endtask

  // expected dout follows from a simple memory model
  task automatic add_step(input op_kind_t k, input ram_addr_t a_rd,
                          input ram_addr_t a_wr, input ram_data_t d);
    step_t     s;
    ram_data_t pat_word;
    s.kind = k;
    s.ra   = a_rd;
    s.wa   = a_wr;
    s.data = d;
    case (k)
      op_write:    model_mem[a_wr] = d;
      op_read:     last_dout = model_mem[a_rd];
      op_wr_rd: begin
        model_mem[a_wr] = d;
        last_dout       = d;
      end
      op_bypass:   last_dout = d;
      op_mb_write: begin
        // every data bit takes the pattern bit of the same position mod 2
        for (int j = 0; j < `RAM_DATA_W; j++) begin
          pat_word[j] = d[j % `MBIST_DI_W];
        end
        model_mem[a_wr] = pat_word;
      end
      op_mb_read:  last_dout = model_mem[a_rd];
      default:     ;
    endcase
    s.exp = last_dout;
    steps.push_back(s);
  endtask

  task automatic build_table();
    last_dout = '0;
    add_step(op_write,    7'd0,  7'd0,  rand_word());
    add_step(op_write,    7'd5,  7'd5,  rand_word());
    add_step(op_write,    7'd79, 7'd79, rand_word());
    add_step(op_read,     7'd0,  7'd0,  '0);
    add_step(op_read,     7'd79, 7'd79, '0);
    add_step(op_read,     7'd5,  7'd5,  '0);
    add_step(op_write,    7'd5,  7'd5,  rand_word());
    add_step(op_read,     7'd5,  7'd5,  '0);
    add_step(op_wr_rd,    7'd33, 7'd33, rand_word());
    add_step(op_idle,     7'd0,  7'd0,  '0);
    add_step(op_read,     7'd33, 7'd33, '0);
    add_step(op_bypass,   7'd0,  7'd0,  rand_word());
    add_step(op_mb_write, 7'd0,  7'd40, 72'b10);
    add_step(op_mb_read,  7'd40, 7'd0,  72'b10);
    add_step(op_read,     7'd79, 7'd79, '0);
    add_step(op_read,     7'd5,  7'd5,  '0);
  endtask

  task automatic check_outputs(input integer idx, input ram_data_t exp);
    checks++;
    assert (dout === exp) else begin
      $display("Error at %0d ns: step %0d dout %h, expected %h", $time, idx, dout, exp);
      errors++;
    end
    assert (mbist_do === exp) else begin
      $display("Error at %0d ns: step %0d mbist_do %h, expected %h",
               $time, idx, mbist_do, exp);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // waits, each bounded
  // ------------------------------------------------------------
  task automatic wait_reset_release();
    integer n;
    n = 0;
    while (mbist_ramaccess_rst_ !== 1'b1 && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (mbist_ramaccess_rst_ !== 1'b1) begin
      $display("timeout: reset was never released");
      timeouts++;
    end
  endtask

  // func_active shows the registered mbist enable
  task automatic set_mbist_mode(input logic on);
    integer n;
    mbist_en = on;
    n = 0;
    @(negedge clk);
    while (UUT.func_active !== !on && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (UUT.func_active !== !on) begin
      $display("timeout: mbist mode %s never took effect", on ? "entry" : "exit");
      timeouts++;
    end
    in_mbist = on;
  endtask

  // ------------------------------------------------------------
  // step execution, always entered on a falling edge
  // ------------------------------------------------------------
  task automatic apply_step(input integer idx);
    step_t s;
    s = steps[idx];
    case (s.kind)
      op_write: begin
        we = 1'b1;
        wa = s.wa;
        di = s.data;
        @(negedge clk);
        drive_idle();
      end
      op_read, op_bypass: begin
        re = 1'b1;
        ra = s.ra;
        @(negedge clk);
        drive_idle();
        ore = 1'b1;
        // bypass only during the capture cycle
        byp_sel = (s.kind == op_bypass);
        dbyp    = s.data;
        @(negedge clk);
        drive_idle();
      end
      op_wr_rd: begin
        re = 1'b1;
        we = 1'b1;
        ra = s.ra;
        wa = s.wa;
        di = s.data;
        @(negedge clk);
        drive_idle();
        ore = 1'b1;
        @(negedge clk);
        drive_idle();
        check_outputs(idx, s.exp);
        // a second capture with re low still sees the forwarded word
        ore = 1'b1;
        @(negedge clk);
        drive_idle();
      end
      op_mb_write: begin
        drive_func_noise();
        mbist_we = 1'b1;
        mbist_wa = s.wa;
        mbist_di = s.data[`MBIST_DI_W-1:0];
        @(negedge clk);
        drive_idle();
      end
      op_mb_read: begin
        drive_func_noise();
        mbist_ce = 1'b1;
        mbist_ra = s.ra;
        @(negedge clk);
        drive_idle();
        @(negedge clk);
      end
      default: begin
        @(negedge clk);
      end
    endcase
    check_outputs(idx, s.exp);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    logic mb;
    seed     = 74;
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    in_mbist = 1'b0;
    mbist_ramaccess_rst_ = 1'b0;
    mbist_en = 1'b0;
    ra       = '0;
    wa       = '0;
    di       = '0;
    dbyp     = '0;
    mbist_ra = '0;
    mbist_wa = '0;
    mbist_di = '0;
    drive_idle();
    build_table();
    wait_reset_release();
    // nothing captured yet
    check_outputs(-1, '0);
    for (int i = 0; i < steps.size() && timeouts == 0; i++) begin
      mb = (steps[i].kind == op_mb_write) || (steps[i].kind == op_mb_read);
      if (mb != in_mbist) begin
        set_mbist_mode(mb);
      end
      if (timeouts == 0) begin
        apply_step(i);
      end
    end
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+.
ram_wrap_pkg.sv
ram_port_mux.sv
ram_array.sv
ram_wthru_ctrl.sv
ram_dout_capture.sv
ram_wrap_top.sv
tb_ram_wrap.sv
